// File: common/bubble_macros.svh
`ifndef BUBBLE_MACROS_SVH
`define BUBBLE_MACROS_SVH

// Phase counter landmarks
`define BD_START_PHASE     18   // Loaded on coil start
`define BD_LOOP_FIRST      20   // Loop target after a full rotation
`define BD_LOOP_LAST       139  // Last phase of a rotation
`define BD_STOP_JUMP_FROM  45   // Stop shortcut source
`define BD_STOP_JUMP_TO    166  // Stop shortcut target
`define BD_COIL_LAST       168  // End of run-down

// Data windows, one bit each
`define BD_WIN0_FIRST      24
`define BD_WIN0_LAST       33
`define BD_WIN1_FIRST      84
`define BD_WIN1_LAST       93

`define BD_POSCHG_FIRST    138  // Position change up to loop last
`define BD_REP_FIRST       141  // Replicator window
`define BD_REP_LAST        143

// Page geometry, two bits per position
`define BD_POSITIONS       64
`define BD_POS_W           6
`define BD_PAGE_BITS       (2 * `BD_POSITIONS)
`define BD_INDEX_W         7

// Stream credits
`define BD_CREDITS         4
`define BD_CREDIT_W        3

`endif

// File: common/bubblePkg.sv
package bubblePkg;

    // Coil sequencer states
    // IDLE   coil off, counter parked at zero
    // START  counter loaded, running up to the loop phase
    // SHIFT  full rotations, loop or stop decided at the last phase
    // STOP   run-down until the coil drops
    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,
        START = 2'd1,
        SHIFT = 2'd2,
        STOP  = 2'd3
    } seqState_t;

    // Field phase counter value
    // 0 is idle, 18..168 is the coil-on range
    typedef logic [7:0] phase_t;

endpackage

// File: common/timingIf.sv
interface timingIf;
    import bubblePkg::*;

    phase_t phase;        // Raw counter value
    logic coilRun;        // Coil driven, 18..168
    logic positionChange; // 138..139
    logic repWindow;      // 141..143
    logic dataWindow;     // Either data window
    logic windowEnd;      // Last phase of a data window

    // Phase counter drives everything
    modport producer
    (
        output phase, coilRun, positionChange, repWindow, dataWindow, windowEnd
    );

    modport sequencer
    (
        input phase, coilRun
    );

    modport store
    (
        input windowEnd, positionChange, coilRun
    );

    modport stream
    (
        input windowEnd
    );

endinterface

// File: timing/coilSequencer.sv
`include "bubble_macros.svh"

module coilSequencer
(
    input  logic                clock12MHz,
    input  logic                rstN,
    input  logic                shiftEnable,
    input  logic                replicatorEnable,
    input  logic                bootloopEnable,
    input  logic                creditOk,
    timingIf.sequencer          tim,
    output logic                cmdStart,
    output logic                cmdStop,
    output logic                cmdLoop,
    output logic                bootloopSync,
    output logic                replicatorSync,
    output bubblePkg::seqState_t state
);
    import bubblePkg::*;

    logic [2:0] shiftPipe; // Three-flop synchronizers
    logic [2:0] repPipe;
    logic [2:0] bootPipe;
    logic       shiftSync;
    logic       rotationGo;
    seqState_t  nextState;

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
        begin
            shiftPipe <= '0;
            repPipe   <= '0;
            bootPipe  <= '0;
        end
        else
        begin
            shiftPipe <= {shiftPipe[1:0], shiftEnable};
            repPipe   <= {repPipe[1:0], replicatorEnable};
            bootPipe  <= {bootPipe[1:0], bootloopEnable};
        end
    end

    assign shiftSync      = shiftPipe[2]; // 3 cycles late
    assign replicatorSync = repPipe[2];
    assign bootloopSync   = bootPipe[2];

    // Host still wants shifting and two bits can be taken
    assign rotationGo = shiftSync && creditOk;

    always_comb
    begin
        nextState = state;
        cmdStart  = 1'b0;
        cmdStop   = 1'b0;
        cmdLoop   = 1'b0;
        case (state)
            IDLE:
                if (rotationGo && !tim.coilRun)
                begin
                    cmdStart  = 1'b1; // Counter loads 18 next cycle
                    nextState = START;
                end
            START:
                if (tim.phase == phase_t'(`BD_LOOP_FIRST - 1))
                    nextState = SHIFT; // In SHIFT from phase 20
            SHIFT:
                if (tim.phase == phase_t'(`BD_LOOP_LAST))
                begin
                    if (rotationGo)
                        cmdLoop = 1'b1; // Another rotation
                    else
                    begin
                        cmdStop   = 1'b1;
                        nextState = STOP;
                    end
                end
            STOP:
                if (tim.phase == phase_t'(`BD_COIL_LAST))
                    nextState = IDLE; // Counter wraps to 0 with us
            default:
                nextState = IDLE;
        endcase
    end

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
            state <= IDLE;
        else
            state <= nextState;
    end

    assert property (@(posedge clock12MHz) disable iff (!rstN) !(cmdStart && cmdStop));

    // Loop only from the last rotation phase
    assert property (@(posedge clock12MHz) disable iff (!rstN)
        cmdLoop |-> tim.phase == phase_t'(`BD_LOOP_LAST));

endmodule

// File: timing/phaseCounter.sv
`include "bubble_macros.svh"

module phaseCounter
(
    input  logic       clock12MHz,
    input  logic       rstN,
    input  logic       cmdStart,
    input  logic       cmdStop,
    input  logic       cmdLoop,
    timingIf.producer  tim
);
    import bubblePkg::*;

    phase_t phase;
    logic   stopping; // Stop taken, shortcut armed

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
        begin
            phase    <= '0;
            stopping <= 1'b0;
        end
        else if (cmdStart)
        begin
            phase    <= phase_t'(`BD_START_PHASE);
            stopping <= 1'b0;
        end
        else if (cmdLoop)
            phase <= phase_t'(`BD_LOOP_FIRST); // Next rotation
        else if (phase == '0)
            phase <= '0; // Parked
        else
        begin
            if (cmdStop)
                stopping <= 1'b1;
            if ((stopping || cmdStop) && phase == phase_t'(`BD_STOP_JUMP_FROM))
                phase <= phase_t'(`BD_STOP_JUMP_TO); // Skip to run-down
            else if (phase == phase_t'(`BD_COIL_LAST))
            begin
                phase    <= '0; // Coil off
                stopping <= 1'b0;
            end
            else
                phase <= phase + 1'b1;
        end
    end

    // Strobe decode, straight from the counter
    assign tim.phase   = phase;
    assign tim.coilRun = (phase >= phase_t'(`BD_START_PHASE))
                      && (phase <= phase_t'(`BD_COIL_LAST));
    assign tim.positionChange = (phase >= phase_t'(`BD_POSCHG_FIRST))
                             && (phase <= phase_t'(`BD_LOOP_LAST));
    assign tim.repWindow = (phase >= phase_t'(`BD_REP_FIRST))
                        && (phase <= phase_t'(`BD_REP_LAST));

    // Two data windows per rotation
    assign tim.dataWindow = ((phase >= phase_t'(`BD_WIN0_FIRST))
                             && (phase <= phase_t'(`BD_WIN0_LAST)))
                         || ((phase >= phase_t'(`BD_WIN1_FIRST))
                             && (phase <= phase_t'(`BD_WIN1_LAST)));
    assign tim.windowEnd = (phase == phase_t'(`BD_WIN0_LAST))
                        || (phase == phase_t'(`BD_WIN1_LAST)); // One cycle each

    // Counter stays inside the coil range
    assert property (@(posedge clock12MHz) disable iff (!rstN)
        phase <= phase_t'(`BD_COIL_LAST));

endmodule

// File: hdl/pageStore.sv
`include "bubble_macros.svh"

module pageStore
(
    input  logic                   clock12MHz,
    input  logic                   rstN,
    input  logic                   loadValid,
    input  logic                   loadPage,
    input  logic [`BD_INDEX_W-1:0] loadIndex,
    input  logic                   loadData,
    input  logic                   pageSelect, // 1 selects bootloop page
    timingIf.store                 tim,
    output logic                   bitOut
);

    logic [`BD_PAGE_BITS-1:0] pageMem [2]; // Program page, bootloop page
    logic [`BD_POS_W-1:0]     position;
    logic                     posChangeD; // Edge detect on positionChange
    logic                     windowIdx;  // 0 first window, 1 second

    // Host load only while the coil is off
    always_ff @(posedge clock12MHz)
    begin
        if (loadValid && !tim.coilRun)
            pageMem[loadPage][loadIndex] <= loadData;
    end

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
        begin
            position   <= '0;
            posChangeD <= 1'b0;
            windowIdx  <= 1'b0;
        end
        else
        begin
            posChangeD <= tim.positionChange;
            if (!tim.coilRun)
            begin
                position  <= '0; // Coil off loses position
                windowIdx <= 1'b0;
            end
            else
            begin
                if (tim.positionChange && !posChangeD)
                    position <= position + 1'b1; // Wraps 63 to 0
                if (tim.positionChange)
                    windowIdx <= 1'b0;
                else if (tim.windowEnd)
                    windowIdx <= ~windowIdx;
            end
        end
    end

    assign bitOut = pageMem[pageSelect][{position, windowIdx}];

    assert property (@(posedge clock12MHz) disable iff (!rstN) loadValid |-> !tim.coilRun);

endmodule

// File: hdl/bitStreamer.sv
`include "bubble_macros.svh"

module bitStreamer
(
    input  logic     clock12MHz,
    input  logic     rstN,
    input  logic     bitIn,
    input  logic     creditReturn, // One credit per pulse
    timingIf.stream  tim,
    output logic     bitValid,
    output logic     bitData,
    output logic     creditOk
);

    logic [`BD_CREDIT_W-1:0] creditCount;

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
            bitValid <= 1'b0;
        else
            bitValid <= tim.windowEnd; // Cycle after window end
    end

    always_ff @(posedge clock12MHz)
    begin
        if (tim.windowEnd)
            bitData <= bitIn;
    end

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
            creditCount <= `BD_CREDIT_W'(`BD_CREDITS); // Full at reset
        else
        begin
            case ({bitValid, creditReturn})
                2'b10:
                    creditCount <= creditCount - 1'b1;
                2'b01:
                    if (creditCount < `BD_CREDIT_W'(`BD_CREDITS))
                        creditCount <= creditCount + 1'b1; // Saturate
                default:
                    creditCount <= creditCount; // Spend and return cancel
            endcase
        end
    end

    // Enough for a whole rotation
    assign creditOk = creditCount >= `BD_CREDIT_W'(2);

    // Wrap below zero would show up above the maximum
    assert property (@(posedge clock12MHz) disable iff (!rstN)
        creditCount <= `BD_CREDIT_W'(`BD_CREDITS));

    // Sequencer gating must leave a credit for every window
    assert property (@(posedge clock12MHz) disable iff (!rstN)
        bitValid |-> creditCount != '0);

endmodule

// File: hdl/bubbleDrive.sv
`include "bubble_macros.svh"

module bubbleDrive
(
    input  logic                   clock12MHz,
    input  logic                   rstN,
    input  logic                   shiftEnable,
    input  logic                   replicatorEnable,
    input  logic                   bootloopEnable,
    input  logic                   loadValid,
    input  logic                   loadPage,
    input  logic [`BD_INDEX_W-1:0] loadIndex,
    input  logic                   loadData,
    input  logic                   creditReturn,
    output logic                   bitValid,
    output logic                   bitData,
    output logic                   bubbleAccess,
    output logic                   positionChange,
    output logic                   positionLatch,
    output logic                   pageSelectOut
);
    import bubblePkg::*;

    logic      cmdStart;
    logic      cmdStop;
    logic      cmdLoop;
    logic      creditOk;
    logic      bootloopSync;
    logic      replicatorSync;
    logic      storeBit; // Selected page bit
    seqState_t seqState;

    timingIf timBus ();

    coilSequencer coilSequencer_inst
    (
        .clock12MHz       (clock12MHz),
        .rstN             (rstN),
        .shiftEnable      (shiftEnable),
        .replicatorEnable (replicatorEnable),
        .bootloopEnable   (bootloopEnable),
        .creditOk         (creditOk),
        .tim              (timBus.sequencer),
        .cmdStart         (cmdStart),
        .cmdStop          (cmdStop),
        .cmdLoop          (cmdLoop),
        .bootloopSync     (bootloopSync),
        .replicatorSync   (replicatorSync),
        .state            (seqState)
    );

    phaseCounter phaseCounter_inst
    (
        .clock12MHz (clock12MHz),
        .rstN       (rstN),
        .cmdStart   (cmdStart),
        .cmdStop    (cmdStop),
        .cmdLoop    (cmdLoop),
        .tim        (timBus.producer)
    );

    pageStore pageStore_inst
    (
        .clock12MHz (clock12MHz),
        .rstN       (rstN),
        .loadValid  (loadValid),
        .loadPage   (loadPage),
        .loadIndex  (loadIndex),
        .loadData   (loadData),
        .pageSelect (bootloopSync),
        .tim        (timBus.store),
        .bitOut     (storeBit)
    );

    bitStreamer bitStreamer_inst
    (
        .clock12MHz   (clock12MHz),
        .rstN         (rstN),
        .bitIn        (storeBit),
        .creditReturn (creditReturn),
        .tim          (timBus.stream),
        .bitValid     (bitValid),
        .bitData      (bitData),
        .creditOk     (creditOk)
    );

    assign bubbleAccess   = timBus.coilRun;
    assign positionChange = timBus.positionChange;
    assign positionLatch  = bootloopSync & replicatorSync & timBus.repWindow; // Replicator latch
    assign pageSelectOut  = bootloopSync;

    // Sequencer and counter agree on when the coil is off
    assert property (@(posedge clock12MHz) disable iff (!rstN)
        (seqState == IDLE) == !timBus.coilRun);

endmodule

// File: testbench/clockGen.sv
module clockGen
#(
    parameter int period      = 10,
    parameter int resetCycles = 5
)
(
    output logic clock12MHz,
    output logic rstN
);

    initial
    begin
        clock12MHz = 1'b0;
        forever
            #(period / 2) clock12MHz = ~clock12MHz; // Free running
    end

    // Release just after an edge, away from the DUT sampling point
    initial
    begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clock12MHz);
        #1;
        rstN = 1'b1;
    end

endmodule

// File: testbench/bubbleDriveTb.sv
`include "bubble_macros.svh"

module bubbleDriveTb;

    localparam int clockPeriod     = 10;
    localparam int rotationCycles  = 151; // Phase 18 through 168
    // Load, program order, bootloop, credit limit, replicator, stop
    localparam int runRotations    = 2 + 66 + 5 + 6 + 5 + 4;
    localparam int marginRotations = 12;

    logic                     clock12MHz;
    logic                     rstN;
    logic                     shiftEnable;
    logic                     replicatorEnable;
    logic                     bootloopEnable;
    logic                     loadValid;
    logic                     loadPage;
    logic [`BD_INDEX_W-1:0]   loadIndex;
    logic                     loadData;
    logic                     creditReturn;
    logic                     bitValid;
    logic                     bitData;
    logic                     bubbleAccess;
    logic                     positionChange;
    logic                     positionLatch;
    logic                     pageSelectOut;

    logic [`BD_PAGE_BITS-1:0] refPage [2]; // Reference copy of both pages
    logic [`BD_INDEX_W-1:0]   expIdx;      // Next bit index in this session
    logic                     expBit;
    logic                     latchAllowed;
    int                       refCredits;
    int                       latchRises;  // Latch pulses this session
    logic                     latchPrev;
    int                       posChgRises; // Position changes since stop request
    logic                     posChgPrev;
    int                       bitTotal;
    int                       bitMark;
    int                       cycleCount;

    logic   quiet;          // Outputs must stay low
    logic   stopping;       // shiftEnable dropped, run-down pending
    logic   autoReturn;     // Host returns a credit per bit
    int     pendingReturns;
    integer seed;
    int     errorCount;
    int     testErrors;
    int     testsRun;
    int     testsFailed;

    clockGen #(.period(clockPeriod), .resetCycles(5)) clockGen_inst
    (
        .clock12MHz (clock12MHz),
        .rstN       (rstN)
    );

    bubbleDrive bubbleDrive_inst
    (
        .clock12MHz       (clock12MHz),
        .rstN             (rstN),
        .shiftEnable      (shiftEnable),
        .replicatorEnable (replicatorEnable),
        .bootloopEnable   (bootloopEnable),
        .loadValid        (loadValid),
        .loadPage         (loadPage),
        .loadIndex        (loadIndex),
        .loadData         (loadData),
        .creditReturn     (creditReturn),
        .bitValid         (bitValid),
        .bitData          (bitData),
        .bubbleAccess     (bubbleAccess),
        .positionChange   (positionChange),
        .positionLatch    (positionLatch),
        .pageSelectOut    (pageSelectOut)
    );

    assign expBit       = refPage[bootloopEnable][expIdx]; // Page follows bootloop request
    assign latchAllowed = bootloopEnable && replicatorEnable;

    always_ff @(posedge clock12MHz)
        cycleCount <= cycleCount + 1;

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
        begin
            expIdx      <= '0;
            refCredits  <= `BD_CREDITS;
            latchRises  <= 0;
            latchPrev   <= 1'b0;
            posChgRises <= 0;
            posChgPrev  <= 1'b0;
            bitTotal    <= 0;
        end
        else
        begin
            if (!bubbleAccess)
                expIdx <= '0; // Coil off loses the position
            else if (bitValid)
                expIdx <= expIdx + 1'b1; // Wraps after 127
            // Spend per bit, return per pulse, capped
            if (bitValid && !creditReturn && refCredits > 0)
                refCredits <= refCredits - 1;
            else if (creditReturn && !bitValid && refCredits < `BD_CREDITS)
                refCredits <= refCredits + 1;
            latchPrev <= positionLatch;
            if (!bubbleAccess)
                latchRises <= 0;
            else if (positionLatch && !latchPrev)
                latchRises <= latchRises + 1;
            posChgPrev <= positionChange;
            if (!stopping)
                posChgRises <= 0;
            else if (positionChange && !posChgPrev)
                posChgRises <= posChgRises + 1;
            bitTotal <= bitTotal + int'(bitValid);
        end
    end

    task automatic valueError(input string name, input int expected, input int actual);
        $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic plainError(input string what);
        $display("Error at %0t: %s", $time, what);
        errorCount++;
    endtask

    // Quiet during reset and whenever idle is expected
    assert property (@(posedge clock12MHz) (quiet || !rstN) && cycleCount > 0
        |-> !(bitValid || bubbleAccess || positionChange || positionLatch))
    else
        plainError("drive output active while it should be idle");

    assert property (@(posedge clock12MHz) disable iff (!rstN) bitValid |-> bitData == expBit)
    else
        valueError("bitData", $sampled(expBit), $sampled(bitData));

    assert property (@(posedge clock12MHz) disable iff (!rstN)
        bubbleAccess |-> pageSelectOut == bootloopEnable)
    else
        valueError("pageSelectOut", $sampled(bootloopEnable), $sampled(pageSelectOut));

    assert property (@(posedge clock12MHz) disable iff (!rstN) bitValid |-> refCredits > 0)
    else
        plainError("bitValid issued with no credit held");

    assert property (@(posedge clock12MHz) disable iff (!rstN) positionLatch |-> bubbleAccess)
    else
        plainError("positionLatch outside bubbleAccess");

    assert property (@(posedge clock12MHz) disable iff (!rstN) positionLatch |-> latchAllowed)
    else
        plainError("positionLatch without both bootloop and replicator requests");

    assert property (@(posedge clock12MHz) disable iff (!rstN) latchRises <= 1)
    else
        valueError("positionLatch pulses", 1, $sampled(latchRises));

    // Each session ends in the run-down, which crosses the replicator window
    assert property (@(posedge clock12MHz) disable iff (!rstN)
        $fell(bubbleAccess) && latchAllowed |-> latchRises == 1)
    else
        valueError("positionLatch pulses", 1, $sampled(latchRises));

    // Last pulse of the session may still be high on the first stopping edge
    assert property (@(posedge clock12MHz) disable iff (!rstN) stopping |=> !bitValid)
    else
        plainError("bitValid after shiftEnable fell");

    assert property (@(posedge clock12MHz) disable iff (!rstN) posChgRises <= 1)
    else
        plainError("positionChange kept pulsing after shiftEnable fell");

    // Host side of the credit stream, only driver of creditReturn
    initial
    begin
        creditReturn   = 1'b0;
        pendingReturns = 0;
        forever
        begin
            @(posedge clock12MHz);
            #1;
            if (autoReturn && bitValid)
                pendingReturns = pendingReturns + 1;
            creditReturn = pendingReturns > 0;
            if (pendingReturns > 0)
                pendingReturns = pendingReturns - 1;
        end
    end

    task automatic skipCycles(input int n);
        repeat (n) @(posedge clock12MHz);
        #1;
    endtask

    task automatic waitBits(input int count);
        int seen;
        int left;
        seen = 0;
        left = (count / 2 + 2) * rotationCycles;
        while (seen < count && left > 0)
        begin
            skipCycles(1);
            if (bitValid)
                seen++;
            left--;
        end
        if (seen < count)
            plainError($sformatf("only %0d of %0d bits arrived in time", seen, count));
    endtask

    task automatic waitAccess(input logic level, input int limit, input string what);
        int left;
        left = limit;
        while (bubbleAccess !== level && left > 0)
        begin
            skipCycles(1);
            left--;
        end
        if (bubbleAccess !== level)
            plainError({"bubbleAccess did not ", what});
    endtask

    task automatic startShift;
        quiet       = 1'b0;
        shiftEnable = 1'b1;
    endtask

    // Called just after the second bit of a rotation
    task automatic stopAndWait;
        stopping    = 1'b1;
        shiftEnable = 1'b0;
        waitAccess(1'b0, 2 * rotationCycles, "fall after shiftEnable fell");
        stopping = 1'b0;
        quiet    = 1'b1;
        skipCycles(10);
    endtask

    task automatic loadPages;
        int p;
        int i;
        int randWord;
        for (p = 0; p < 2; p++)
        begin
            for (i = 0; i < `BD_PAGE_BITS; i++)
            begin
                randWord      = $random(seed);
                loadValid     = 1'b1;
                loadPage      = p[0];
                loadIndex     = i[`BD_INDEX_W-1:0];
                loadData      = randWord[0];
                refPage[p][i] = randWord[0];
                skipCycles(1);
            end
        end
        loadValid = 1'b0;
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount == testErrors)
            $display("test %0d %s: ok", testsRun, name);
        else
        begin
            testsFailed++;
            $display("test %0d %s: %0d errors", testsRun, name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    initial
    begin
        seed             = 39247;
        shiftEnable      = 1'b0;
        replicatorEnable = 1'b0;
        bootloopEnable   = 1'b0;
        loadValid        = 1'b0;
        loadPage         = 1'b0;
        loadIndex        = '0;
        loadData         = 1'b0;
        quiet            = 1'b1;
        stopping         = 1'b0;
        autoReturn       = 1'b1;
        errorCount       = 0;
        testErrors       = 0;
        testsRun         = 0;
        testsFailed      = 0;
        @(posedge rstN);
        skipCycles(20);
        finishTest("reset");

        loadPages();
        startShift();
        waitBits(130); // Crosses the wrap from 127 to 0
        stopAndWait();
        finishTest("program page order");

        bootloopEnable = 1'b1;
        startShift();
        waitBits(8);
        stopAndWait();
        finishTest("bootloop page");

        bootloopEnable = 1'b0;
        pendingReturns = pendingReturns + `BD_CREDITS; // Top up to the maximum
        skipCycles(8);
        autoReturn = 1'b0;
        bitMark    = bitTotal;
        startShift();
        waitAccess(1'b1, 20, "rise on start");
        waitAccess(1'b0, 3 * rotationCycles, "fall with credits spent");
        skipCycles(20);
        assert (bitTotal - bitMark == `BD_CREDITS)
        else
            valueError("bitValid pulses", `BD_CREDITS, bitTotal - bitMark);
        assert (!bubbleAccess)
        else
            plainError("coil restarted with no credits");
        autoReturn     = 1'b1;
        pendingReturns = pendingReturns + `BD_CREDITS;
        waitAccess(1'b1, 20, "rise after credits returned");
        waitBits(4);
        stopAndWait();
        finishTest("credit limit");

        bootloopEnable   = 1'b1;
        replicatorEnable = 1'b1;
        startShift();
        waitBits(4);
        stopAndWait();
        bootloopEnable = 1'b0; // Replicator alone latches nothing
        startShift();
        waitBits(2);
        stopAndWait();
        replicatorEnable = 1'b0;
        finishTest("replicator latch");

        startShift();
        waitBits(2);
        stopAndWait();
        skipCycles(2 * rotationCycles); // Idle, nothing may move
        finishTest("stop sequence");

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        #((runRotations + marginRotations) * rotationCycles * clockPeriod);
        $display("Watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/bubblePkg.sv
common/timingIf.sv
timing/coilSequencer.sv
timing/phaseCounter.sv
hdl/pageStore.sv
hdl/bitStreamer.sv
hdl/bubbleDrive.sv
testbench/clockGen.sv
testbench/bubbleDriveTb.sv

// File: Bender.yml
package:
  name: bubble_drive

sources:
  - include_dirs:
      - common
    files:
      - common/bubblePkg.sv
      - common/timingIf.sv
      - timing/coilSequencer.sv
      - timing/phaseCounter.sv
      - hdl/pageStore.sv
      - hdl/bitStreamer.sv
      - hdl/bubbleDrive.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/clockGen.sv
      - testbench/bubbleDriveTb.sv
